// File: filelist.f
logic/tmds_pkg.sv
logic/tmds_period_scheduler.sv
logic/tmds_channel.sv
logic/tmds_word_packer.sv
logic/hdmi_tmds_encoder.sv
testbench/tb_clock_gen.sv
testbench/tb_hdmi_tmds_encoder.sv

// File: logic/hdmi_tmds_encoder.sv
/* HDMI TMDS encoder top level
   Period scheduler, three lane encoders and the transceiver word packer */
`timescale 1ns/1ps

module hdmi_tmds_encoder
    import tmds_pkg::*;
(
    input  logic              clk_pixel,
    input  logic              arst_n,
    input  logic              de,
    input  logic              hsync,
    input  logic              vsync,
    input  logic [23:0]       pixel,
    input  logic              island_start,
    input  logic [9:0]        island_data,
    output logic              island_take,
    output logic [WORD_W-1:0] tmds_word,
    output logic              tmds_word_valid
);

    logic [2:0]          lane_period [NUM_LANES];
    lane_payload_u       lane_payload [NUM_LANES];
    logic [SYMBOL_W-1:0] lane_symbol [NUM_LANES];

    tmds_period_scheduler tmds_period_scheduler_i (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .de           (de),
        .hsync        (hsync),
        .vsync        (vsync),
        .pixel        (pixel),
        .island_start (island_start),
        .island_data  (island_data),
        .island_take  (island_take),
        .period       (lane_period),
        .payload      (lane_payload)
    );

    // Blue, green and red lanes
    for (genvar lane = 0; lane < NUM_LANES; lane++)
    begin : g_lane
        tmds_channel #(
            .LANE (lane)
        ) tmds_channel_i (
            .clk_pixel (clk_pixel),
            .arst_n    (arst_n),
            .period    (lane_period[lane]),
            .payload   (lane_payload[lane]),
            .symbol    (lane_symbol[lane])
        );
    end

    tmds_word_packer tmds_word_packer_i (
        .clk_pixel       (clk_pixel),
        .arst_n          (arst_n),
        .symbols         (lane_symbol),
        .tmds_word       (tmds_word),
        .tmds_word_valid (tmds_word_valid)
    );

endmodule

// File: logic/tmds_channel.sv
/* TMDS channel encoder
   Video with running disparity, control codes, TERC4 and guard bands for one lane */
`timescale 1ns/1ps

module tmds_channel
    import tmds_pkg::*;
#(
    // Lane number, 0 to 2
    parameter int LANE = 0
)
(
    input  logic                clk_pixel,
    input  logic                arst_n,
    input  logic [2:0]          period,
    input  lane_payload_u       payload,
    output logic [SYMBOL_W-1:0] symbol
);

    logic [7:0]          d;
    logic [3:0]          n1_d;
    logic                use_xnor;
    logic [8:0]          q_m;
    logic signed [4:0]   n1_qm;
    logic signed [4:0]   n0_qm;
    logic signed [4:0]   acc;
    logic signed [4:0]   acc_add;
    logic [SYMBOL_W-1:0] q_out;
    logic [SYMBOL_W-1:0] island_guard;
    logic [SYMBOL_W-1:0] symbol_next;

    assign d = payload.pixel;

    // Stage 1 of the transition-minimised code
    always_comb
    begin
        n1_d = '0;
        for (int i = 0; i < 8; i++)
            n1_d = n1_d + 4'(d[i]);
        use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !d[0]);
    end

    // Each bit chains off the one below it
    always_comb
    begin
        q_m[0] = d[0];
        for (int i = 1; i < 8; i++)
        begin
            if (use_xnor)
                q_m[i] = q_m[i-1] ~^ d[i];
            else
                q_m[i] = q_m[i-1] ^ d[i];
        end
        q_m[8] = !use_xnor;
    end

    always_comb
    begin
        n1_qm = 5'sd0;
        for (int i = 0; i < 8; i++)
            n1_qm = n1_qm + $signed({4'b0000, q_m[i]});
        n0_qm = 5'sd8 - n1_qm;
    end

    // Stage 2, DC balance against the running disparity
    always_comb
    begin
        if (acc == 5'sd0 || n1_qm == n0_qm)
        begin
            if (q_m[8])
            begin
                q_out = {1'b0, 1'b1, q_m[7:0]};
                acc_add = n1_qm - n0_qm;
            end
            else
            begin
                q_out = {1'b1, 1'b0, ~q_m[7:0]};
                acc_add = n0_qm - n1_qm;
            end
        end
        else if ((acc > 5'sd0 && n1_qm > n0_qm) || (acc < 5'sd0 && n1_qm < n0_qm))
        begin
            q_out = {1'b1, q_m[8], ~q_m[7:0]};
            acc_add = (n0_qm - n1_qm) + (q_m[8] ? 5'sd2 : 5'sd0);
        end
        else
        begin
            q_out = {1'b0, q_m[8], q_m[7:0]};
            acc_add = (n1_qm - n0_qm) - (q_m[8] ? 5'sd0 : 5'sd2);
        end
    end

    // Lane 0 guard follows the sync pair like TERC4 codes 0xC to 0xF
    always_comb
    begin
        if (LANE == 0)
            island_guard = TERC4_SYMBOLS[{2'b11, payload.aux.ctrl}];
        else
            island_guard = ISLAND_GUARD_SYMBOL;
    end

    always_comb
    begin
        case (period)
            PERIOD_CONTROL:      symbol_next = CTRL_SYMBOLS[payload.aux.ctrl];
            PERIOD_VIDEO:        symbol_next = q_out;
            PERIOD_VIDEO_GUARD:  symbol_next = VIDEO_GUARD_SYMBOLS[LANE];
            PERIOD_ISLAND:       symbol_next = TERC4_SYMBOLS[payload.aux.nibble];
            PERIOD_ISLAND_GUARD: symbol_next = island_guard;
            default:             symbol_next = CTRL_SYMBOLS[0];
        endcase
    end

    // Disparity only runs during video
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            acc <= 5'sd0;
            symbol <= CTRL_SYMBOLS[0];
        end
        else
        begin
            if (period == PERIOD_VIDEO)
                acc <= acc + acc_add;
            else
                acc <= 5'sd0;
            symbol <= symbol_next;
        end
    end

endmodule

// File: logic/tmds_period_scheduler.sv
/* HDMI period scheduler
   Delays video by the lead time and sequences preambles, guard bands and data islands */
`timescale 1ns/1ps

module tmds_period_scheduler
    import tmds_pkg::*;
(
    input  logic                clk_pixel,
    input  logic                arst_n,
    input  logic                de,
    input  logic                hsync,
    input  logic                vsync,
    input  logic [23:0]         pixel,
    input  logic                island_start,
    input  logic [9:0]          island_data,
    output logic                island_take,
    output logic [2:0]          period [NUM_LANES],
    output lane_payload_u       payload [NUM_LANES]
);

    // Stage 0 is the newest entry, {de, hsync, vsync}
    logic [VIDEO_LEAD-1:0][2:0]  timing_dly;
    logic [VIDEO_LEAD-1:0][23:0] pixel_dly;
    logic                        de_d;
    logic                        hsync_d;
    logic                        vsync_d;
    logic [23:0]                 pixel_d;
    logic                        de_rise;

    logic [SEQ_W-1:0]            state;
    logic [SEQ_W-1:0]            eff_state;
    logic [SEQ_W-1:0]            state_next;
    logic [PHASE_W-1:0]          phase;
    logic [PHASE_W-1:0]          eff_phase;
    logic [PHASE_W-1:0]          phase_next;
    logic                        seq_last;

    logic [2:0]                  cur_period;
    logic [3:0]                  ctl_pattern;
    logic [9:0]                  island_word;
    logic [5:0]                  lane_ctrl;
    logic [11:0]                 lane_nibble;
    lane_payload_u               lane_pay [NUM_LANES];

    assign de_d    = timing_dly[VIDEO_LEAD-1][2];
    assign hsync_d = timing_dly[VIDEO_LEAD-1][1];
    assign vsync_d = timing_dly[VIDEO_LEAD-1][0];
    assign pixel_d = pixel_dly[VIDEO_LEAD-1];
    assign de_rise = de && !timing_dly[0][2];

    // Data is sampled from the source on every island data cycle
    assign island_take = (state == SEQ_ISLAND_DATA);
    assign island_word = island_take ? island_data : '0;

    // A new sequence takes effect in the cycle that starts it
    always_comb
    begin
        eff_state = state;
        eff_phase = phase;
        if (state == SEQ_IDLE)
        begin
            if (de_rise)
            begin
                eff_state = SEQ_VIDEO_PRE;
                eff_phase = '0;
            end
            else if (island_start && !de_d)
            begin
                eff_state = SEQ_ISLAND_PRE;
                eff_phase = '0;
            end
        end
    end

    always_comb
    begin
        case (eff_state)
            SEQ_VIDEO_PRE, SEQ_ISLAND_PRE:
                seq_last = (eff_phase == PHASE_W'(PREAMBLE_LEN - 1));
            SEQ_VIDEO_GUARD, SEQ_ISLAND_LEAD, SEQ_ISLAND_TRAIL:
                seq_last = (eff_phase == PHASE_W'(GUARD_LEN - 1));
            SEQ_ISLAND_DATA:
                seq_last = (eff_phase == PHASE_W'(ISLAND_LEN - 1));
            default:
                seq_last = 1'b0;
        endcase

        state_next = eff_state;
        phase_next = (eff_state == SEQ_IDLE) ? '0 : eff_phase + 1'b1;
        if (seq_last)
        begin
            phase_next = '0;
            case (eff_state)
                SEQ_VIDEO_PRE:    state_next = SEQ_VIDEO_GUARD;
                SEQ_ISLAND_PRE:   state_next = SEQ_ISLAND_LEAD;
                SEQ_ISLAND_LEAD:  state_next = SEQ_ISLAND_DATA;
                SEQ_ISLAND_DATA:  state_next = SEQ_ISLAND_TRAIL;
                default:          state_next = SEQ_IDLE;
            endcase
        end
    end

    always_comb
    begin
        ctl_pattern = '0;
        case (eff_state)
            SEQ_VIDEO_PRE:
            begin
                cur_period = PERIOD_CONTROL;
                ctl_pattern = VIDEO_PREAMBLE_CTL;
            end
            SEQ_ISLAND_PRE:
            begin
                cur_period = PERIOD_CONTROL;
                ctl_pattern = ISLAND_PREAMBLE_CTL;
            end
            SEQ_VIDEO_GUARD:                   cur_period = PERIOD_VIDEO_GUARD;
            SEQ_ISLAND_LEAD, SEQ_ISLAND_TRAIL: cur_period = PERIOD_ISLAND_GUARD;
            SEQ_ISLAND_DATA:                   cur_period = PERIOD_ISLAND;
            default:                           cur_period = PERIOD_CONTROL;
        endcase
        // Delayed video always wins
        if (de_d)
            cur_period = PERIOD_VIDEO;
    end

    // Lane i takes bits [2i+:2] of the control pairs and [4i+:4] of the nibbles
    assign lane_ctrl   = {ctl_pattern, vsync_d, hsync_d};
    assign lane_nibble = {island_word, vsync_d, hsync_d};

    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
        begin
            lane_pay[i] = '0;
            if (cur_period == PERIOD_VIDEO)
            begin
                lane_pay[i].pixel = pixel_d[8*i +: 8];
            end
            else
            begin
                lane_pay[i].aux.ctrl = lane_ctrl[2*i +: 2];
                lane_pay[i].aux.nibble = lane_nibble[4*i +: 4];
            end
        end
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= SEQ_IDLE;
            phase <= '0;
            timing_dly <= '0;
            for (int i = 0; i < NUM_LANES; i++)
                period[i] <= PERIOD_CONTROL;
        end
        else
        begin
            state <= state_next;
            phase <= phase_next;
            timing_dly <= {timing_dly[VIDEO_LEAD-2:0], {de, hsync, vsync}};
            for (int i = 0; i < NUM_LANES; i++)
                period[i] <= cur_period;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        pixel_dly <= {pixel_dly[VIDEO_LEAD-2:0], pixel};
        for (int i = 0; i < NUM_LANES; i++)
            payload[i] <= lane_pay[i];
    end

endmodule

// File: logic/tmds_pkg.sv
/* TMDS encoder shared definitions
   Period codes, symbol tables, preamble patterns and the lane payload word */
package tmds_pkg;

    localparam int NUM_LANES = 3;
    localparam int SYMBOL_W = 10;
    localparam int WORD_W = 32;
    localparam int PIXEL_SYMBOL_W = NUM_LANES * SYMBOL_W;
    localparam int FILL_W = $clog2(2 * WORD_W);

    localparam int PREAMBLE_LEN = 8;
    localparam int GUARD_LEN = 2;
    localparam int ISLAND_LEN = 32;
    localparam int VIDEO_LEAD = PREAMBLE_LEN + GUARD_LEN;
    localparam int PHASE_W = $clog2(ISLAND_LEN);

    // Period codes seen by every channel
    localparam logic [2:0] PERIOD_CONTROL = 3'd0;
    localparam logic [2:0] PERIOD_VIDEO = 3'd1;
    localparam logic [2:0] PERIOD_VIDEO_GUARD = 3'd2;
    localparam logic [2:0] PERIOD_ISLAND = 3'd3;
    localparam logic [2:0] PERIOD_ISLAND_GUARD = 3'd4;

    // Scheduler sequence states
    localparam int SEQ_W = 3;
    localparam logic [SEQ_W-1:0] SEQ_IDLE = 3'd0;
    localparam logic [SEQ_W-1:0] SEQ_VIDEO_PRE = 3'd1;
    localparam logic [SEQ_W-1:0] SEQ_VIDEO_GUARD = 3'd2;
    localparam logic [SEQ_W-1:0] SEQ_ISLAND_PRE = 3'd3;
    localparam logic [SEQ_W-1:0] SEQ_ISLAND_LEAD = 3'd4;
    localparam logic [SEQ_W-1:0] SEQ_ISLAND_DATA = 3'd5;
    localparam logic [SEQ_W-1:0] SEQ_ISLAND_TRAIL = 3'd6;

    // Control period codes, indexed by the control pair
    localparam logic [SYMBOL_W-1:0] CTRL_SYMBOLS [4] = '{
        10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011
    };

    // TERC4 codes, indexed by the nibble
    localparam logic [SYMBOL_W-1:0] TERC4_SYMBOLS [16] = '{
        10'b1010011100, 10'b1001100011, 10'b1011100100, 10'b1011100010,
        10'b0101110001, 10'b0100011110, 10'b0110001110, 10'b0100111100,
        10'b1011001100, 10'b0100111001, 10'b0110011100, 10'b1011000110,
        10'b1010001110, 10'b1001110001, 10'b0101100011, 10'b1011000011
    };

    localparam logic [SYMBOL_W-1:0] VIDEO_GUARD_SYMBOLS [NUM_LANES] = '{
        10'b1011001100, 10'b0100110011, 10'b1011001100
    };
    // Lanes 1 and 2 only, lane 0 derives its guard from the syncs
    localparam logic [SYMBOL_W-1:0] ISLAND_GUARD_SYMBOL = 10'b0100110011;

    // CTL3..CTL0, CTL0 in bit 0
    localparam logic [3:0] VIDEO_PREAMBLE_CTL = 4'b0001;
    localparam logic [3:0] ISLAND_PREAMBLE_CTL = 4'b0101;

    // Pixel byte during video, TERC4 nibble and control pair elsewhere
    typedef union packed {
        logic [7:0] pixel;
        struct packed {
            logic [1:0] spare;
            logic [3:0] nibble;
            logic [1:0] ctrl;
        } aux;
    } lane_payload_u;

endpackage

// File: logic/tmds_word_packer.sv
/* TMDS word packer
   Repacks 30 symbol bits per pixel into 32-bit words with a valid strobe */
`timescale 1ns/1ps

module tmds_word_packer
    import tmds_pkg::*;
(
    input  logic                clk_pixel,
    input  logic                arst_n,
    input  logic [SYMBOL_W-1:0] symbols [NUM_LANES],
    output logic [WORD_W-1:0]   tmds_word,
    output logic                tmds_word_valid
);

    logic [PIXEL_SYMBOL_W-1:0] pixel_bits;
    logic [WORD_W-1:0]         held;
    logic [FILL_W-1:0]         fill;
    logic [FILL_W-1:0]         fill_sum;
    logic [2*WORD_W-1:0]       joined;
    logic                      emit;

    // Lane 0 occupies the lowest stream bits
    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
            pixel_bits[SYMBOL_W*i +: SYMBOL_W] = symbols[i];
    end

    // Bits above the fill level in the buffer are ignored
    always_comb
    begin
        joined = ((2*WORD_W)'(held) & (((2*WORD_W)'(1) << fill) - 1'b1))
            | ((2*WORD_W)'(pixel_bits) << fill);
        fill_sum = fill + FILL_W'(PIXEL_SYMBOL_W);
        emit = (fill_sum >= FILL_W'(WORD_W));
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fill <= '0;
            tmds_word_valid <= 1'b0;
        end
        else
        begin
            fill <= emit ? fill_sum - FILL_W'(WORD_W) : fill_sum;
            tmds_word_valid <= emit;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        tmds_word <= joined[WORD_W-1:0];
        if (emit)
            held <= joined[2*WORD_W-1:WORD_W];
        else
            held <= joined[WORD_W-1:0];
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the HDMI TMDS encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_hdmi_tmds_encoder -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation run succeeded" || {
    echo "Simulation run did not succeed"
    exit 1
}

// File: testbench/tb_clock_gen.sv
/* Testbench clock and reset
   100 ns pixel clock, reset held low for the first 3 cycles */
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk_pixel,
    output logic arst_n
);

    initial
    begin
        clk_pixel = 1'b0;
        forever #50 clk_pixel = ~clk_pixel;
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk_pixel);
        @(negedge clk_pixel);
        arst_n = 1'b1;
    end

endmodule

// File: testbench/tb_hdmi_tmds_encoder.sv
/* HDMI TMDS encoder testbench
   Directed tests checked against a TMDS reference model on the unpacked word stream */
`timescale 1ns/1ps

module tb_hdmi_tmds_encoder
    import tmds_pkg::*;
();

    typedef logic [NUM_LANES-1:0][SYMBOL_W-1:0] pix_sym_t;

    // Reset plus the driven length of the five tests
    localparam int TEST_CYCLES = 3 + 60 + 80 + 100 + 100 + 80;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 200;
    localparam pix_sym_t IDLE_PIXEL = {NUM_LANES{CTRL_SYMBOLS[0]}};

    logic              clk_pixel;
    logic              arst_n;
    logic              de;
    logic              hsync;
    logic              vsync;
    logic [23:0]       pixel;
    logic              island_start;
    logic [9:0]        island_data;
    logic              island_take;
    logic [WORD_W-1:0] tmds_word;
    logic              tmds_word_valid;

    bit                stream_bits [$];
    logic [WORD_W-1:0] words [$];
    int                cursor;
    int                cycle_count;

    tb_clock_gen tb_clock_gen_i (
        .clk_pixel (clk_pixel),
        .arst_n    (arst_n)
    );

    hdmi_tmds_encoder hdmi_tmds_encoder_i (
        .clk_pixel       (clk_pixel),
        .arst_n          (arst_n),
        .de              (de),
        .hsync           (hsync),
        .vsync           (vsync),
        .pixel           (pixel),
        .island_start    (island_start),
        .island_data     (island_data),
        .island_take     (island_take),
        .tmds_word       (tmds_word),
        .tmds_word_valid (tmds_word_valid)
    );

    task automatic report_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_symbol(input string name, input logic [SYMBOL_W-1:0] got,
                                input logic [SYMBOL_W-1:0] exp);
        if (got !== exp)
        begin
            $display("** Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp)
        begin
            $display("** Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_payload(input string name, input lane_payload_u got,
                                 input lane_payload_u exp);
        if (got !== exp)
        begin
            $display("** Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("** Error at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    // Stream bits are appended LSB first as each valid word arrives
    always @(negedge clk_pixel)
    begin
        if (arst_n && tmds_word_valid)
        begin
            words.push_back(tmds_word);
            for (int b = 0; b < WORD_W; b++)
                stream_bits.push_back(tmds_word[b]);
        end
    end

    always @(posedge clk_pixel)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            report_failure();
        end
    end

    // Pixel symbol k, lane 0 in the lowest stream bits
    task automatic get_pixel(input int k, output pix_sym_t sym);
        while (stream_bits.size() < PIXEL_SYMBOL_W * (k + 1))
            @(negedge clk_pixel);
        for (int b = 0; b < PIXEL_SYMBOL_W; b++)
            sym[b / SYMBOL_W][b % SYMBOL_W] = stream_bits[PIXEL_SYMBOL_W * k + b];
    endtask

    task automatic find_start();
        pix_sym_t sym;
        bit       idle;
        idle = 1'b1;
        while (idle)
        begin
            get_pixel(cursor, sym);
            idle = (sym == IDLE_PIXEL);
            if (idle)
                cursor++;
        end
    endtask

    task automatic check_sequence(input pix_sym_t exp [$], input string what);
        pix_sym_t sym;
        find_start();
        foreach (exp[i])
        begin
            get_pixel(cursor, sym);
            for (int l = 0; l < NUM_LANES; l++)
                check_symbol($sformatf("%s symbol %0d lane %0d", what, i, l), sym[l], exp[i][l]);
            cursor++;
        end
    endtask

    // Transition-minimised code with DC balance
    task automatic encode_video(input logic [7:0] d, inout int disp,
                                output logic [SYMBOL_W-1:0] q);
        int         n1d;
        int         diff;
        logic [8:0] qm;
        bit         use_xnor;
        n1d = $countones(d);
        use_xnor = (n1d > 4) || (n1d == 4 && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++)
            qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        qm[8] = !use_xnor;
        diff = 2 * $countones(qm[7:0]) - 8;
        if (disp == 0 || diff == 0)
        begin
            q = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            disp += qm[8] ? diff : -diff;
        end
        else if ((disp > 0 && diff > 0) || (disp < 0 && diff < 0))
        begin
            q = {1'b1, qm[8], ~qm[7:0]};
            disp += (qm[8] ? 2 : 0) - diff;
        end
        else
        begin
            q = {1'b0, qm[8], qm[7:0]};
            disp += diff - (qm[8] ? 0 : 2);
        end
    endtask

    task automatic build_video_expect(input logic [23:0] pix [$], output pix_sym_t exp [$]);
        int                  disp [NUM_LANES];
        pix_sym_t            s;
        logic [SYMBOL_W-1:0] q;
        exp = {};
        disp = '{default: 0};
        s[0] = CTRL_SYMBOLS[0];
        s[1] = CTRL_SYMBOLS[VIDEO_PREAMBLE_CTL[1:0]];
        s[2] = CTRL_SYMBOLS[VIDEO_PREAMBLE_CTL[3:2]];
        repeat (PREAMBLE_LEN) exp.push_back(s);
        for (int l = 0; l < NUM_LANES; l++)
            s[l] = VIDEO_GUARD_SYMBOLS[l];
        repeat (GUARD_LEN) exp.push_back(s);
        foreach (pix[i])
        begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
                encode_video(pix[i][8*l +: 8], disp[l], q);
                s[l] = q;
            end
            exp.push_back(s);
        end
        repeat (4) exp.push_back(IDLE_PIXEL);
    endtask

    task automatic drive_video_line(input logic [23:0] pix [$]);
        foreach (pix[i])
        begin
            @(negedge clk_pixel);
            de = 1'b1;
            pixel = pix[i];
        end
        @(negedge clk_pixel);
        de = 1'b0;
        pixel = '0;
    endtask

    task automatic reset_idle_test();
        logic [1:0] syncs [$];
        pix_sym_t   exp [$];
        pix_sym_t   s;
        // First pair is nonzero so it marks the start of the sequence
        syncs.push_back(2'b01);
        repeat (19) syncs.push_back(2'($urandom_range(3)));
        foreach (syncs[i])
        begin
            @(negedge clk_pixel);
            {vsync, hsync} = syncs[i];
            s[0] = CTRL_SYMBOLS[syncs[i]];
            s[1] = CTRL_SYMBOLS[0];
            s[2] = CTRL_SYMBOLS[0];
            exp.push_back(s);
        end
        @(negedge clk_pixel);
        {vsync, hsync} = 2'b00;
        repeat (30) @(negedge clk_pixel);
        repeat (4) exp.push_back(IDLE_PIXEL);
        check_sequence(exp, "idle");
    endtask

    task automatic video_line_test();
        logic [23:0] pix [$];
        pix_sym_t    exp [$];
        repeat (40) pix.push_back(24'($urandom));
        drive_video_line(pix);
        repeat (30) @(negedge clk_pixel);
        build_video_expect(pix, exp);
        check_sequence(exp, "video");
    endtask

    task automatic disparity_reset_test();
        logic [23:0] line_a [$];
        logic [23:0] line_b [$];
        pix_sym_t    exp [$];
        // Odd count of 0xFF pixels leaves the disparity nonzero
        repeat (11) line_a.push_back(24'hFFFFFF);
        for (int i = 0; i < 12; i++)
            line_b.push_back((i % 2 == 0) ? 24'hFFFFFF : 24'h000000);
        drive_video_line(line_a);
        repeat (30) @(negedge clk_pixel);
        drive_video_line(line_b);
        repeat (30) @(negedge clk_pixel);
        build_video_expect(line_a, exp);
        check_sequence(exp, "first line");
        build_video_expect(line_b, exp);
        check_sequence(exp, "second line");
    endtask

    task automatic data_island_test();
        logic [9:0]    data [ISLAND_LEN];
        int            n;
        pix_sym_t      sym;
        pix_sym_t      s;
        lane_payload_u got;
        lane_payload_u exp;
        bit            found;
        foreach (data[i])
            data[i] = 10'($urandom);
        n = 0;
        @(negedge clk_pixel);
        island_start = 1'b1;
        for (int c = 0; c < 60; c++)
        begin
            @(negedge clk_pixel);
            island_start = 1'b0;
            island_data = (n < ISLAND_LEN) ? data[n] : '0;
            if (island_take)
                n++;
        end
        check_count("island_take cycles", n, ISLAND_LEN);
        repeat (30) @(negedge clk_pixel);

        find_start();
        s[0] = CTRL_SYMBOLS[0];
        s[1] = CTRL_SYMBOLS[ISLAND_PREAMBLE_CTL[1:0]];
        s[2] = CTRL_SYMBOLS[ISLAND_PREAMBLE_CTL[3:2]];
        for (int i = 0; i < PREAMBLE_LEN + GUARD_LEN + ISLAND_LEN + GUARD_LEN + 4; i++)
        begin
            get_pixel(cursor, sym);
            if (i == PREAMBLE_LEN)
                s = {ISLAND_GUARD_SYMBOL, ISLAND_GUARD_SYMBOL, TERC4_SYMBOLS[12]};
            else if (i == PREAMBLE_LEN + GUARD_LEN + ISLAND_LEN + GUARD_LEN)
                s = IDLE_PIXEL;
            if (i >= PREAMBLE_LEN + GUARD_LEN && i < PREAMBLE_LEN + GUARD_LEN + ISLAND_LEN)
            begin
                // Decode each TERC4 symbol back to its nibble
                for (int l = 0; l < NUM_LANES; l++)
                begin
                    got = '0;
                    exp = '0;
                    found = 1'b0;
                    for (int t = 0; t < 16; t++)
                    begin
                        if (sym[l] == TERC4_SYMBOLS[t])
                        begin
                            got.aux.nibble = 4'(t);
                            found = 1'b1;
                        end
                    end
                    if (!found)
                    begin
                        $display("Island symbol %0d on lane %0d is not a TERC4 code",
                                 i - PREAMBLE_LEN - GUARD_LEN, l);
                        report_failure();
                    end
                    if (l == 0)
                        exp.aux.nibble = {data[i-PREAMBLE_LEN-GUARD_LEN][1:0], 2'b00};
                    else
                        exp.aux.nibble = data[i-PREAMBLE_LEN-GUARD_LEN][4*l-2 +: 4];
                    check_payload($sformatf("island payload %0d lane %0d",
                                  i - PREAMBLE_LEN - GUARD_LEN, l), got, exp);
                end
            end
            else
            begin
                for (int l = 0; l < NUM_LANES; l++)
                    check_symbol($sformatf("island symbol %0d lane %0d", i, l), sym[l], s[l]);
            end
            cursor++;
        end
    endtask

    task automatic packing_test();
        logic [23:0]       pix [$];
        pix_sym_t          exp [$];
        pix_sym_t          sym;
        int                valid_count;
        int                start;
        int                first_bit;
        int                last_bit;
        int                p;
        logic [WORD_W-1:0] ew;
        repeat (30) pix.push_back(24'($urandom));
        valid_count = 0;
        for (int c = 0; c < 48; c++)
        begin
            @(negedge clk_pixel);
            if (tmds_word_valid)
                valid_count++;
            de = (c < 30);
            pixel = (c < 30) ? pix[c] : '0;
        end
        check_count("valid words in 48 cycles", valid_count, 45);
        repeat (30) @(negedge clk_pixel);
        build_video_expect(pix, exp);
        // Align on the preamble, then wait for the whole line in the stream
        find_start();
        start = cursor;
        get_pixel(start + exp.size() - 1, sym);
        cursor = start + exp.size();
        first_bit = PIXEL_SYMBOL_W * start;
        last_bit = PIXEL_SYMBOL_W * (start + exp.size());
        for (int j = (first_bit + WORD_W - 1) / WORD_W; WORD_W * (j + 1) <= last_bit; j++)
        begin
            for (int b = 0; b < WORD_W; b++)
            begin
                p = WORD_W * j + b - first_bit;
                ew[b] = exp[p / PIXEL_SYMBOL_W][(p % PIXEL_SYMBOL_W) / SYMBOL_W][p % SYMBOL_W];
            end
            check_word($sformatf("tmds_word %0d", j), words[j], ew);
        end
    endtask

    initial
    begin
        void'($urandom(32'he064_a87f));
        de = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        pixel = '0;
        island_start = 1'b0;
        island_data = '0;
        cursor = 0;
        cycle_count = 0;
        wait (arst_n === 1'b1);
        @(negedge clk_pixel);

        reset_idle_test();
        video_line_test();
        disparity_reset_test();
        data_island_test();
        packing_test();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
